/* all.f */
+incdir+logic
+incdir+tb
logic/breakoutPkg.sv
logic/brickTable.sv
logic/objectTracker.sv
logic/drawSequencer.sv
logic/rectRasterizer.sv
logic/breakoutDatapath.sv
tb/breakoutDatapathTb.sv

/* logic/breakoutDatapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module breakoutDatapath
(
    input  logic                 clk,
    input  logic                 ld_reset,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  breakoutPkg::drawOp_t cmdOp,
    input  logic [3:0]           cmdBrick,
    input  logic [`X_W-1:0]      cmdPosX,
    input  logic [`Y_W-1:0]      cmdPosY,
    output logic                 pixValid,
    output logic [`X_W-1:0]      pixX,
    output logic [`Y_W-1:0]      pixY,
    output logic [`COLOUR_W-1:0] pixColour,
    input  logic                 pixReady
);

    logic [3:0]             brickIndex;
    logic [`NUM_BRICKS-1:0] brickAlive;
    logic [`X_W-1:0]        brickOriginX;
    logic [`Y_W-1:0]        brickOriginY;
    logic                   populateAll;
    logic                   removeBrick;
    logic                   movePaddle;
    logic                   moveBall;
    logic [`X_W-1:0]        newX;
    logic [`Y_W-1:0]        newY;
    logic [`X_W-1:0]        paddleX;
    logic [`X_W-1:0]        oldPaddleX;
    logic [`X_W-1:0]        ballX;
    logic [`Y_W-1:0]        ballY;
    logic [`X_W-1:0]        oldBallX;
    logic [`Y_W-1:0]        oldBallY;
    logic                   jobValid;
    logic [`X_W-1:0]        jobX;
    logic [`Y_W-1:0]        jobY;
    logic [`X_W-1:0]        jobW;
    logic [`Y_W-1:0]        jobH;
    logic [`COLOUR_W-1:0]   jobColour;
    logic                   jobDone;

    brickTable brickTableInst (.*);

    objectTracker objectTrackerInst (.*);

    // decodes commands into strobes and rectangle jobs
    drawSequencer drawSequencerInst (.*);

    rectRasterizer rectRasterizerInst (.*);

endmodule

`default_nettype wire

/* logic/breakoutPkg.sv */
`default_nettype none

package breakoutPkg;

    // draw commands accepted on the command port
    typedef enum logic [3:0] {
        OP_POPULATE     = 4'd0,
        OP_DRAW_BRICK   = 4'd1,
        OP_REMOVE_BRICK = 4'd2,
        OP_MOVE_PADDLE  = 4'd3,
        OP_MOVE_BALL    = 4'd4,
        OP_ERASE_PADDLE = 4'd5,
        OP_DRAW_PADDLE  = 4'd6,
        OP_ERASE_BALL   = 4'd7,
        OP_DRAW_BALL    = 4'd8
    } drawOp_t;

    // the rasterizer is either waiting for a job or walking one
    typedef enum logic {
        RS_IDLE = 1'b0,
        RS_RUN  = 1'b1
    } rasterState_t;

endpackage

`default_nettype wire

/* logic/breakout_macros.svh */
`ifndef BREAKOUT_MACROS_SVH
`define BREAKOUT_MACROS_SVH

// coordinate widths cover a 640 by 480 screen
`define X_W 10
`define Y_W 9
`define COLOUR_W 3

// the wall is 3 rows of 4 bricks
`define NUM_BRICKS 12
`define BRICK_COLS 4
`define BRICK_W 120
`define BRICK_H 40
`define BRICK_PITCH_X 140
`define BRICK_PITCH_Y 60
`define BRICK_ORIGIN_X 20
`define BRICK_ORIGIN_Y 20

// the paddle only moves along x, its row is fixed
`define PADDLE_W 80
`define PADDLE_H 20
`define PADDLE_Y 440
`define BALL_SIZE 30

// positions loaded by reset
`define PADDLE_START_X 280
`define BALL_START_X 305
`define BALL_START_Y 300

`define COLOUR_BRICK 3'b111
`define COLOUR_PADDLE 3'b111
`define COLOUR_BALL 3'b100
`define COLOUR_BLANK 3'b000

`endif

/* logic/brickTable.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module brickTable
(
    input  logic                   clk,
    input  logic                   ld_reset,
    input  logic                   populateAll,
    input  logic                   removeBrick,
    input  logic [3:0]             brickIndex,
    output logic [`NUM_BRICKS-1:0] brickAlive,
    output logic [`X_W-1:0]        brickOriginX,
    output logic [`Y_W-1:0]        brickOriginY
);

    logic [3:0] colIdx;
    logic [3:0] rowIdx;
    logic       indexValid;

    assign indexValid = (brickIndex < 4'(`NUM_BRICKS));

    // brick n sits in column n mod 4 and row n div 4
    assign colIdx = brickIndex % 4'(`BRICK_COLS);
    assign rowIdx = brickIndex / 4'(`BRICK_COLS);

    assign brickOriginX = `X_W'(`BRICK_ORIGIN_X)
                        + `X_W'(colIdx) * `X_W'(`BRICK_PITCH_X);
    assign brickOriginY = `Y_W'(`BRICK_ORIGIN_Y)
                        + `Y_W'(rowIdx) * `Y_W'(`BRICK_PITCH_Y);

    always_ff @(posedge clk)
    begin
        if (ld_reset)
        begin
            brickAlive <= '0;
        end
        else if (populateAll)
        begin
            brickAlive <= '1;
        end
        else if (removeBrick && indexValid)
        begin
            // an index past the wall has no bit to clear
            brickAlive[brickIndex] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/drawSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module drawSequencer
(
    input  logic                   clk,
    input  logic                   ld_reset,
    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  breakoutPkg::drawOp_t   cmdOp,
    input  logic [3:0]             cmdBrick,
    input  logic [`X_W-1:0]        cmdPosX,
    input  logic [`Y_W-1:0]        cmdPosY,
    output logic [3:0]             brickIndex,
    input  logic [`NUM_BRICKS-1:0] brickAlive,
    input  logic [`X_W-1:0]        brickOriginX,
    input  logic [`Y_W-1:0]        brickOriginY,
    output logic                   populateAll,
    output logic                   removeBrick,
    output logic                   movePaddle,
    output logic                   moveBall,
    output logic [`X_W-1:0]        newX,
    output logic [`Y_W-1:0]        newY,
    input  logic [`X_W-1:0]        paddleX,
    input  logic [`X_W-1:0]        oldPaddleX,
    input  logic [`X_W-1:0]        ballX,
    input  logic [`Y_W-1:0]        ballY,
    input  logic [`X_W-1:0]        oldBallX,
    input  logic [`Y_W-1:0]        oldBallY,
    output logic                   jobValid,
    output logic [`X_W-1:0]        jobX,
    output logic [`Y_W-1:0]        jobY,
    output logic [`X_W-1:0]        jobW,
    output logic [`Y_W-1:0]        jobH,
    output logic [`COLOUR_W-1:0]   jobColour,
    input  logic                   jobDone
);

    logic accept;
    logic brickLive;
    logic busy;

    assign accept     = cmdValid && cmdReady;
    assign cmdReady   = !busy;
    assign brickIndex = cmdBrick;
    assign newX       = cmdPosX;
    assign newY       = cmdPosY;

    // out-of-range indices count as dead bricks
    assign brickLive = (cmdBrick < 4'(`NUM_BRICKS)) && brickAlive[cmdBrick];

    // the job is handed over in the accept cycle so the first pixel follows one cycle later
    always_comb
    begin
        populateAll = 1'b0;
        removeBrick = 1'b0;
        movePaddle  = 1'b0;
        moveBall    = 1'b0;
        jobValid    = 1'b0;
        jobX        = '0;
        jobY        = '0;
        jobW        = '0;
        jobH        = '0;
        jobColour   = `COLOUR_BLANK;
        case (cmdOp)
            breakoutPkg::OP_POPULATE:
            begin
                populateAll = accept;
            end
            breakoutPkg::OP_DRAW_BRICK, breakoutPkg::OP_REMOVE_BRICK:
            begin
                // a removal clears the bit and paints the same rectangle black
                removeBrick = accept && brickLive && (cmdOp == breakoutPkg::OP_REMOVE_BRICK);
                jobValid    = accept && brickLive;
                jobX        = brickOriginX;
                jobY        = brickOriginY;
                jobW        = `X_W'(`BRICK_W);
                jobH        = `Y_W'(`BRICK_H);
                jobColour   = (cmdOp == breakoutPkg::OP_DRAW_BRICK) ? `COLOUR_BRICK
                                                                   : `COLOUR_BLANK;
            end
            breakoutPkg::OP_MOVE_PADDLE:
            begin
                movePaddle = accept;
            end
            breakoutPkg::OP_MOVE_BALL:
            begin
                moveBall = accept;
            end
            breakoutPkg::OP_ERASE_PADDLE, breakoutPkg::OP_DRAW_PADDLE:
            begin
                jobValid  = accept;
                jobY      = `Y_W'(`PADDLE_Y);
                jobW      = `X_W'(`PADDLE_W);
                jobH      = `Y_W'(`PADDLE_H);
                if (cmdOp == breakoutPkg::OP_DRAW_PADDLE)
                begin
                    jobX      = paddleX;
                    jobColour = `COLOUR_PADDLE;
                end
                else
                begin
                    jobX = oldPaddleX;
                end
            end
            breakoutPkg::OP_ERASE_BALL, breakoutPkg::OP_DRAW_BALL:
            begin
                jobValid = accept;
                jobW     = `X_W'(`BALL_SIZE);
                jobH     = `Y_W'(`BALL_SIZE);
                if (cmdOp == breakoutPkg::OP_DRAW_BALL)
                begin
                    jobX      = ballX;
                    jobY      = ballY;
                    jobColour = `COLOUR_BALL;
                end
                else
                begin
                    jobX = oldBallX;
                    jobY = oldBallY;
                end
            end
            default:
            begin
                // unknown opcodes are accepted and dropped
                jobValid = 1'b0;
            end
        endcase
    end

    // one rectangle in flight at a time, released by the rasterizer's done pulse
    always_ff @(posedge clk)
    begin
        if (ld_reset)
        begin
            busy <= 1'b0;
        end
        else if (jobValid)
        begin
            busy <= 1'b1;
        end
        else if (jobDone)
        begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/objectTracker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module objectTracker
(
    input  logic            clk,
    input  logic            ld_reset,
    input  logic            movePaddle,
    input  logic            moveBall,
    input  logic [`X_W-1:0] newX,
    input  logic [`Y_W-1:0] newY,
    output logic [`X_W-1:0] paddleX,
    output logic [`X_W-1:0] oldPaddleX,
    output logic [`X_W-1:0] ballX,
    output logic [`X_W-1:0] oldBallX,
    output logic [`Y_W-1:0] ballY,
    output logic [`Y_W-1:0] oldBallY
);

    // the previous position is what the next erase has to cover
    always_ff @(posedge clk)
    begin
        if (ld_reset)
        begin
            paddleX    <= `X_W'(`PADDLE_START_X);
            oldPaddleX <= `X_W'(`PADDLE_START_X);
        end
        else if (movePaddle)
        begin
            oldPaddleX <= paddleX;
            paddleX    <= newX;
        end
    end

    // the ball moves in both axes, so both halves shift together
    always_ff @(posedge clk)
    begin
        if (ld_reset)
        begin
            ballX    <= `X_W'(`BALL_START_X);
            ballY    <= `Y_W'(`BALL_START_Y);
            oldBallX <= `X_W'(`BALL_START_X);
            oldBallY <= `Y_W'(`BALL_START_Y);
        end
        else if (moveBall)
        begin
            oldBallX <= ballX;
            oldBallY <= ballY;
            ballX    <= newX;
            ballY    <= newY;
        end
    end

endmodule

`default_nettype wire

/* logic/rectRasterizer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module rectRasterizer
(
    input  logic                 clk,
    input  logic                 ld_reset,
    input  logic                 jobValid,
    input  logic [`X_W-1:0]      jobX,
    input  logic [`Y_W-1:0]      jobY,
    input  logic [`X_W-1:0]      jobW,
    input  logic [`Y_W-1:0]      jobH,
    input  logic [`COLOUR_W-1:0] jobColour,
    output logic                 jobDone,
    output logic                 pixValid,
    output logic [`X_W-1:0]      pixX,
    output logic [`Y_W-1:0]      pixY,
    output logic [`COLOUR_W-1:0] pixColour,
    input  logic                 pixReady
);

    breakoutPkg::rasterState_t state;

    logic [`X_W-1:0]      originX;
    logic [`Y_W-1:0]      originY;
    logic [`X_W-1:0]      widthReg;
    logic [`Y_W-1:0]      heightReg;
    logic [`COLOUR_W-1:0] colourReg;
    logic [`X_W-1:0]      colCnt;
    logic [`Y_W-1:0]      rowCnt;
    logic                 pixFire;
    logic                 lastCol;
    logic                 lastRow;

    // outputs come straight from the latched job, so they hold while stalled
    assign pixValid  = (state == breakoutPkg::RS_RUN);
    assign pixX      = originX + colCnt;
    assign pixY      = originY + rowCnt;
    assign pixColour = colourReg;

    assign pixFire = pixValid && pixReady;
    assign lastCol = (colCnt == widthReg - `X_W'(1));
    assign lastRow = (rowCnt == heightReg - `Y_W'(1));

    always_ff @(posedge clk)
    begin
        if (ld_reset)
        begin
            state   <= breakoutPkg::RS_IDLE;
            jobDone <= 1'b0;
        end
        else
        begin
            jobDone <= 1'b0;
            if (state == breakoutPkg::RS_IDLE && jobValid)
            begin
                state <= breakoutPkg::RS_RUN;
            end
            else if (pixFire && lastCol && lastRow)
            begin
                state   <= breakoutPkg::RS_IDLE;
                jobDone <= 1'b1;
            end
        end
    end

    // job registers and the x-fastest scan counters
    always_ff @(posedge clk)
    begin
        if (state == breakoutPkg::RS_IDLE && jobValid)
        begin
            originX   <= jobX;
            originY   <= jobY;
            widthReg  <= jobW;
            heightReg <= jobH;
            colourReg <= jobColour;
            colCnt    <= '0;
            rowCnt    <= '0;
        end
        else if (pixFire)
        begin
            if (lastCol)
            begin
                colCnt <= '0;
                rowCnt <= rowCnt + `Y_W'(1);
            end
            else
            begin
                colCnt <= colCnt + `X_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# compiles with Verilator, runs the testbench and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module breakoutDatapathTb \
    -f all.f -o simv || exit 1
output="$(./obj_dir/simv)"
echo "$output"
echo "$output" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1

/* tb/breakoutModel.svh */
`ifndef BREAKOUT_MODEL_SVH
`define BREAKOUT_MODEL_SVH

// one expected rectangle, scanned row by row with x fastest
typedef struct packed {
    logic [15:0]          x;
    logic [15:0]          y;
    logic [15:0]          w;
    logic [15:0]          h;
    logic [`COLOUR_W-1:0] colour;
} rect_t;

rect_t                  rects[$];
logic [`NUM_BRICKS-1:0] wallAlive;
int                     paddleNow;
int                     paddleBefore;
int                     ballNowX;
int                     ballNowY;
int                     ballBeforeX;
int                     ballBeforeY;

task automatic queueRect(input int x, input int y, input int w, input int h,
                         input logic [`COLOUR_W-1:0] colour);
    rect_t r;
    r.x = 16'(x);
    r.y = 16'(y);
    r.w = 16'(w);
    r.h = 16'(h);
    r.colour = colour;
    rects.push_back(r);
endtask

task automatic clearModel();
    wallAlive = '0;
    paddleNow = `PADDLE_START_X;
    paddleBefore = `PADDLE_START_X;
    ballNowX = `BALL_START_X;
    ballNowY = `BALL_START_Y;
    ballBeforeX = `BALL_START_X;
    ballBeforeY = `BALL_START_Y;
    rects.delete();
endtask

// updates the wall and positions, and queues whatever the command should draw
task automatic predictCommand(input breakoutPkg::drawOp_t op, input int brick,
                              input int x, input int y);
    int  originX;
    int  originY;
    bit  live;
    originX = `BRICK_ORIGIN_X + (brick % `BRICK_COLS) * `BRICK_PITCH_X;
    originY = `BRICK_ORIGIN_Y + (brick / `BRICK_COLS) * `BRICK_PITCH_Y;
    live = (brick < `NUM_BRICKS) && wallAlive[brick];
    case (op)
        breakoutPkg::OP_POPULATE:
            wallAlive = '1;
        breakoutPkg::OP_DRAW_BRICK:
            if (live)
                queueRect(originX, originY, `BRICK_W, `BRICK_H, `COLOUR_BRICK);
        breakoutPkg::OP_REMOVE_BRICK:
            if (live)
            begin
                queueRect(originX, originY, `BRICK_W, `BRICK_H, `COLOUR_BLANK);
                wallAlive[brick] = 1'b0;
            end
        breakoutPkg::OP_MOVE_PADDLE:
        begin
            paddleBefore = paddleNow;
            paddleNow = x;
        end
        breakoutPkg::OP_MOVE_BALL:
        begin
            ballBeforeX = ballNowX;
            ballBeforeY = ballNowY;
            ballNowX = x;
            ballNowY = y;
        end
        breakoutPkg::OP_ERASE_PADDLE:
            queueRect(paddleBefore, `PADDLE_Y, `PADDLE_W, `PADDLE_H, `COLOUR_BLANK);
        breakoutPkg::OP_DRAW_PADDLE:
            queueRect(paddleNow, `PADDLE_Y, `PADDLE_W, `PADDLE_H, `COLOUR_PADDLE);
        breakoutPkg::OP_ERASE_BALL:
            queueRect(ballBeforeX, ballBeforeY, `BALL_SIZE, `BALL_SIZE, `COLOUR_BLANK);
        breakoutPkg::OP_DRAW_BALL:
            queueRect(ballNowX, ballNowY, `BALL_SIZE, `BALL_SIZE, `COLOUR_BALL);
    endcase
endtask

`endif

/* tb/breakoutDatapathTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "breakout_macros.svh"

module breakoutDatapathTb;

    // 200 commands of up to 4800 pixels, doubled for back-pressure, at 10 ns each
    localparam int WATCHDOG_NS = 200 * 4800 * 2 * 10;

    logic                 clk = 1'b0;
    logic                 ld_reset;
    logic                 cmdValid;
    logic                 cmdReady;
    breakoutPkg::drawOp_t cmdOp;
    logic [3:0]           cmdBrick;
    logic [`X_W-1:0]      cmdPosX;
    logic [`Y_W-1:0]      cmdPosY;
    logic                 pixValid;
    logic [`X_W-1:0]      pixX;
    logic [`Y_W-1:0]      pixY;
    logic [`COLOUR_W-1:0] pixColour;
    logic                 pixReady = 1'b0;

    integer               seed = 32'h6bec;
    int                   errorCount = 0;
    int                   commandCount = 0;
    int                   pixelCount = 0;
    int                   markErrors = 0;
    int                   markCommands = 0;
    int                   markPixels = 0;
    int                   colPos = 0;
    int                   rowPos = 0;
    logic                 stalled = 1'b0;
    logic [`X_W-1:0]      heldX;
    logic [`Y_W-1:0]      heldY;
    logic [`COLOUR_W-1:0] heldColour;

    `include "breakoutModel.svh"

    breakoutDatapath i_dut (.*);

    always #5 clk = ~clk;

    // the sink stalls about one cycle in four
    always @(posedge clk)
        pixReady <= ($unsigned($random(seed)) % 4) != 0;

    initial
    begin
        #WATCHDOG_NS;
        $display("watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic int randomBelow(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // compares one transferring pixel with the head of the expected rectangles
    task automatic checkPixel();
        int expX;
        int expY;
        if (rects.size() == 0)
        begin
            $display("unexpected pixel at %0t while no rectangle was pending", $time);
            errorCount++;
            return;
        end
        expX = int'(rects[0].x) + colPos;
        expY = int'(rects[0].y) + rowPos;
        if (int'(pixX) != expX || int'(pixY) != expY || pixColour != rects[0].colour)
        begin
            $display("Mismatch at %0t: pixel (%0d,%0d) colour %b, expected (%0d,%0d) colour %b",
                     $time, pixX, pixY, pixColour, expX, expY, rects[0].colour);
            errorCount++;
        end
        pixelCount++;
        colPos++;
        if (colPos == int'(rects[0].w))
        begin
            colPos = 0;
            rowPos++;
        end
        if (rowPos == int'(rects[0].h))
        begin
            rowPos = 0;
            void'(rects.pop_front());
        end
    endtask

    // drops what is left of rectangles that should have finished by now
    task automatic checkDrained(input int pending);
        if (rects.size() > pending)
        begin
            $display("rectangle at (%0d,%0d) ended at %0t with %0d pixels missing",
                     rects[0].x, rects[0].y, $time,
                     int'(rects[0].w) * int'(rects[0].h) - rowPos * int'(rects[0].w) - colPos);
            errorCount++;
            while (rects.size() > pending)
                void'(rects.pop_front());
            colPos = 0;
            rowPos = 0;
        end
    endtask

    // both ports settle by the falling edge, so the monitor samples there
    always @(negedge clk)
    begin
        if (!ld_reset)
        begin
            if (pixValid && cmdReady)
            begin
                $display("command port was ready at %0t during a rectangle", $time);
                errorCount++;
            end
            if (stalled && !pixValid)
            begin
                $display("pixValid dropped at %0t before a stalled pixel transferred", $time);
                errorCount++;
            end
            else if (stalled && (pixX != heldX || pixY != heldY || pixColour != heldColour))
            begin
                $display("Mismatch at %0t: stalled pixel changed from (%0d,%0d) to (%0d,%0d)",
                         $time, heldX, heldY, pixX, pixY);
                errorCount++;
            end
            if (pixValid && pixReady)
                checkPixel();
            stalled = pixValid && !pixReady;
            heldX = pixX;
            heldY = pixY;
            heldColour = pixColour;
        end
    end

    // offers one command at once, so it waits on the port while an earlier rectangle drains
    task automatic runCommand(input breakoutPkg::drawOp_t op, input int brick,
                              input int x, input int y);
        int queuedBefore;
        bit expectPixels;
        queuedBefore = rects.size();
        predictCommand(op, brick, x, y);
        expectPixels = (rects.size() != queuedBefore);
        @(posedge clk);
        cmdValid <= 1'b1;
        cmdOp <= op;
        cmdBrick <= 4'(brick);
        cmdPosX <= `X_W'(x);
        cmdPosY <= `Y_W'(y);
        @(negedge clk);
        while (!cmdReady)
            @(negedge clk);
        // a ready port means every earlier rectangle has fully transferred
        checkDrained(expectPixels ? 1 : 0);
        @(posedge clk);
        cmdValid <= 1'b0;
        @(negedge clk);
        if (expectPixels && (cmdReady || !pixValid))
        begin
            $display("opcode %s did not start its rectangle at %0t", op.name(), $time);
            errorCount++;
        end
        if (!expectPixels && (!cmdReady || pixValid))
        begin
            $display("opcode %s drew or stalled when it should not at %0t", op.name(), $time);
            errorCount++;
        end
        commandCount++;
    endtask

    // the last rectangle of a test drains before its summary line
    task automatic finishTest(input string name);
        while (!cmdReady)
            @(negedge clk);
        checkDrained(0);
        $display("test %s: %0d commands, %0d pixels, %0d errors", name,
                 commandCount - markCommands, pixelCount - markPixels, errorCount - markErrors);
        markCommands = commandCount;
        markPixels = pixelCount;
        markErrors = errorCount;
    endtask

    initial
    begin
        int brick;
        ld_reset = 1'b1;
        cmdValid = 1'b0;
        cmdOp = breakoutPkg::OP_POPULATE;
        cmdBrick = '0;
        cmdPosX = '0;
        cmdPosY = '0;
        clearModel();
        repeat (5) @(posedge clk);
        ld_reset <= 1'b0;
        @(negedge clk);
        if (!cmdReady || pixValid)
        begin
            $display("after reset cmdReady was %0b and pixValid was %0b", cmdReady, pixValid);
            errorCount++;
        end
        runCommand(breakoutPkg::OP_DRAW_BRICK, randomBelow(`NUM_BRICKS), 0, 0);
        finishTest("reset and empty wall");

        runCommand(breakoutPkg::OP_POPULATE, 0, 0, 0);
        for (int n = 0; n < `NUM_BRICKS; n++)
            runCommand(breakoutPkg::OP_DRAW_BRICK, n, 0, 0);
        finishTest("populate and draw every brick");

        for (int i = 0; i < 8; i++)
        begin
            brick = randomBelow(`NUM_BRICKS);
            runCommand(breakoutPkg::OP_REMOVE_BRICK, brick, 0, 0);
            runCommand(breakoutPkg::OP_DRAW_BRICK, brick, 0, 0);
        end
        finishTest("remove bricks");

        for (int i = 0; i < 3; i++)
        begin
            runCommand(breakoutPkg::OP_MOVE_PADDLE, 0, randomBelow(561), 0);
            runCommand(breakoutPkg::OP_ERASE_PADDLE, 0, 0, 0);
            runCommand(breakoutPkg::OP_DRAW_PADDLE, 0, 0, 0);
        end
        finishTest("paddle move");

        for (int i = 0; i < 3; i++)
        begin
            runCommand(breakoutPkg::OP_MOVE_BALL, 0, randomBelow(611), randomBelow(451));
            runCommand(breakoutPkg::OP_ERASE_BALL, 0, 0, 0);
            runCommand(breakoutPkg::OP_DRAW_BALL, 0, 0, 0);
        end
        finishTest("ball move");

        for (int i = 0; i < 60; i++)
            runCommand(breakoutPkg::drawOp_t'(4'(randomBelow(9))), randomBelow(`NUM_BRICKS),
                       randomBelow(561), randomBelow(451));
        finishTest("random command mix");

        $display("finished %0d commands, %0d pixels checked, %0d errors",
                 commandCount, pixelCount, errorCount);
        if (errorCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
